// ==== Makefile ====
# Verilator flow for the branch predictor front end.

VERILATOR  ?= verilator
TOP_TB     ?= branch_predict_tb
TOP_RTL    ?= branch_predict_top
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Result: PASSED
TIMESCALE  ?= 1ns/100ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

RTL_SRCS = hw/blt_pkg.sv \
           hw/match_encoder.sv \
           hw/branch_lookup_table.sv \
           hw/resolve_branch.sv \
           hw/fetch_pc.sv \
           hw/branch_predict_top.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP_RTL) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP_TB) \
		-Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP_TB) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/branch_predict_chk.sv ====
`default_nettype none

module branch_predict_chk #(
  parameter int                    ADDR_WIDTH = 32,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  fetch_enable,
  input  wire logic                  resolve_valid,
  input  wire logic                  redirect,
  input  wire blt_pkg::outcome_e     redirect_cause,
  input  wire logic [ADDR_WIDTH-1:0] fetch_pc
);

  timeunit 1ns;
  timeprecision 100ps;

  import blt_pkg::*;

  // redirect only comes from a resolve.
  redirect_needs_resolve: assert property (
    @(posedge clk) disable iff (reset) redirect |-> resolve_valid
  ) else $error("redirect asserted without resolve_valid");

  cause_matches_redirect: assert property (
    @(posedge clk) disable iff (reset) (redirect_cause == OUTCOME_CORRECT) == !redirect
  ) else $error("redirect_cause disagrees with redirect");

  pc_after_reset: assert property (
    @(posedge clk) reset |=> (fetch_pc == RESET_PC)
  ) else $error("fetch_pc is not the reset PC after reset");

  // stalled and no redirect, so the pc holds.
  pc_holds_when_idle: assert property (
    @(posedge clk) disable iff (reset) (!fetch_enable && !redirect) |=> $stable(fetch_pc)
  ) else $error("fetch_pc moved while stalled");

endmodule

`default_nettype wire

// ==== dv/branch_predict_tb.sv ====
`default_nettype none

module branch_predict_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import blt_pkg::*;

  localparam int                    ADDR_WIDTH   = 32;
  localparam int                    BLT_SIZE     = 8;
  localparam logic [ADDR_WIDTH-1:0] RESET_PC     = '0;
  localparam int                    CLK_PERIOD   = 4;
  localparam int                    RESET_CYCLES = 4;
  localparam int                    MAX_WORDS    = 1024;

  // word offsets inside one record.
  localparam int W_KIND     = 0;
  localparam int W_FETCH_EN = 1;
  localparam int W_RPC      = 2;
  localparam int W_RTAKEN   = 3;
  localparam int W_RTARGET  = 4;
  localparam int W_PTAKEN   = 5;
  localparam int W_PTARGET  = 6;
  localparam int W_XREDIR   = 7;
  localparam int W_XCAUSE   = 8;
  localparam int W_XRPC     = 9;
  localparam int W_XPC      = 10;
  localparam int REC_WORDS  = 11;

  localparam logic [31:0] KIND_RESOLVE = 32'h1;
  localparam logic [31:0] KIND_END     = 32'hf;

  logic                  clk;
  logic                  reset;
  logic                  fetch_enable;
  logic                  resolve_valid;
  logic [ADDR_WIDTH-1:0] resolve_pc;
  logic                  resolve_taken;
  logic [ADDR_WIDTH-1:0] resolve_target;
  logic                  predicted_taken;
  logic [ADDR_WIDTH-1:0] predicted_target;

  logic [ADDR_WIDTH-1:0] fetch_pc;
  logic                  predict_taken;
  logic [ADDR_WIDTH-1:0] predict_target;
  logic                  redirect;
  outcome_e              redirect_cause;
  logic [ADDR_WIDTH-1:0] redirect_pc;

  logic [31:0]           tests [MAX_WORDS];
  int                    record_count = 0;
  int                    error_count = 0;
  bit                    verdict_printed = 1'b0;
  logic [ADDR_WIDTH-1:0] expected_pc;

  // reference copy of the table.
  logic [ADDR_WIDTH-1:0] model_key [BLT_SIZE];
  logic [ADDR_WIDTH-1:0] model_val [BLT_SIZE];
  bit                    model_valid [BLT_SIZE];
  bit                    model_taken [BLT_SIZE];
  int                    model_ptr;

  branch_predict_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BLT_SIZE   (BLT_SIZE),
    .RESET_PC   (RESET_PC)
  ) u_dut (
    .clk              (clk),
    .reset            (reset),
    .fetch_enable     (fetch_enable),
    .fetch_pc         (fetch_pc),
    .predict_taken    (predict_taken),
    .predict_target   (predict_target),
    .resolve_valid    (resolve_valid),
    .resolve_pc       (resolve_pc),
    .resolve_taken    (resolve_taken),
    .resolve_target   (resolve_target),
    .predicted_taken  (predicted_taken),
    .predicted_target (predicted_target),
    .redirect         (redirect),
    .redirect_cause   (redirect_cause),
    .redirect_pc      (redirect_pc)
  );

  bind branch_predict_top branch_predict_chk #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RESET_PC   (RESET_PC)
  ) u_chk (
    .clk            (clk),
    .reset          (reset),
    .fetch_enable   (fetch_enable),
    .resolve_valid  (resolve_valid),
    .redirect       (redirect),
    .redirect_cause (redirect_cause),
    .fetch_pc       (fetch_pc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Result: FAILED");
      verdict_printed = 1'b1;
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic int lookup(input logic [ADDR_WIDTH-1:0] key);
    for (int i = 0; i < BLT_SIZE; i++) begin
      if (model_valid[i] && model_key[i] == key) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic clear_table();
    for (int i = 0; i < BLT_SIZE; i++) begin
      model_valid[i] = 1'b0;
      model_taken[i] = 1'b0;
    end
    model_ptr = 0;
  endtask

  // hit updates in place, miss fills the round-robin slot.
  task automatic table_update(input logic [ADDR_WIDTH-1:0] key,
                              input logic [ADDR_WIDTH-1:0] val, input bit tk);
    int slot;
    slot = lookup(key);
    if (slot < 0) begin
      slot = model_ptr;
      model_key[slot]   = key;
      model_valid[slot] = 1'b1;
      model_ptr         = (model_ptr + 1) % BLT_SIZE;
    end
    model_val[slot]   = val;
    model_taken[slot] = tk;
  endtask

  task automatic check_prediction();
    int slot;
    bit exp_taken;
    slot = lookup(fetch_pc);
    exp_taken = 1'b0;
    if (slot >= 0) begin
      exp_taken = model_taken[slot];
    end
    compare(32'(predict_taken), 32'(exp_taken), "predict_taken");
    if (exp_taken) begin
      compare(predict_target, model_val[slot], "predict_target");
    end
  endtask

  function automatic int count_records();
    int n;
    n = 0;
    while ((n + 1) * REC_WORDS <= MAX_WORDS && tests[n * REC_WORDS] !== KIND_END &&
           !$isunknown(tests[n * REC_WORDS])) begin
      n++;
    end
    return n;
  endfunction

  // one record per cycle; fetch_pc seen here is the result of the previous record.
  task automatic run_record(input int base);
    bit is_resolve;
    bit r_taken;
    bit p_taken;
    is_resolve = tests[base + W_KIND] == KIND_RESOLVE;
    r_taken    = tests[base + W_RTAKEN][0];
    p_taken    = tests[base + W_PTAKEN][0];
    @(posedge clk);
    fetch_enable     <= tests[base + W_FETCH_EN][0];
    resolve_valid    <= is_resolve;
    resolve_pc       <= tests[base + W_RPC];
    resolve_taken    <= r_taken;
    resolve_target   <= tests[base + W_RTARGET];
    predicted_taken  <= p_taken;
    predicted_target <= tests[base + W_PTARGET];
    @(negedge clk);
    compare(fetch_pc, expected_pc, "fetch_pc");
    check_prediction();
    compare(32'(redirect), tests[base + W_XREDIR], "redirect");
    compare(32'(redirect_cause), tests[base + W_XCAUSE], "redirect_cause");
    if (is_resolve) begin
      compare(redirect_pc, tests[base + W_XRPC], "redirect_pc");
      if (r_taken || p_taken) begin
        table_update(tests[base + W_RPC],
                     r_taken ? tests[base + W_RTARGET] : tests[base + W_PTARGET], r_taken);
      end
    end
    expected_pc = tests[base + W_XPC];
  endtask

  task automatic run_all_records();
    for (int r = 0; r < record_count; r++) begin
      run_record(r * REC_WORDS);
    end
    @(posedge clk);
    fetch_enable  <= 1'b0;
    resolve_valid <= 1'b0;
    @(negedge clk);
    compare(fetch_pc, expected_pc, "fetch_pc");  // last record's edge.
  endtask

  initial begin
    clk              = 1'b0;
    reset            = 1'b1;
    fetch_enable     = 1'b0;
    resolve_valid    = 1'b0;
    resolve_pc       = '0;
    resolve_taken    = 1'b0;
    resolve_target   = '0;
    predicted_taken  = 1'b0;
    predicted_target = '0;
    expected_pc      = RESET_PC;
    clear_table();
    $readmemh("dv/branch_predict_tests.txt", tests);
    record_count = count_records();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    if (record_count == 0) begin
      $display("no test records were loaded from dv/branch_predict_tests.txt");
      $display("Result: FAILED");
      verdict_printed = 1'b1;
      $fatal(1, "empty stimulus");
    end else begin
      run_all_records();
      if (error_count == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      verdict_printed = 1'b1;
      $finish;
    end
  end

  initial begin
    int limit_cycles;
    wait (record_count > 0);
    limit_cycles = record_count * 10;
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Result: FAILED");
    verdict_printed = 1'b1;
    $fatal(1, "watchdog expired");
  end

  // an assertion can end the run before any verdict.
  final begin
    if (!verdict_printed) begin
      $display("Result: FAILED");
    end
  end

endmodule

`default_nettype wire

// ==== dv/branch_predict_tests.txt ====
// kind fetch_en resolve_pc resolve_taken resolve_target pred_taken pred_target
// exp_redirect exp_cause exp_redirect_pc exp_fetch_pc (kind 0 fetch, 1 resolve, f end)
// sequential fetch and stall
0 1 000 0 000 0 000 0 0 000 004
0 1 000 0 000 0 000 0 0 000 008
0 0 000 0 000 0 000 0 0 000 008
0 1 000 0 000 0 000 0 0 000 00c
0 1 000 0 000 0 000 0 0 000 010
// loop branch at 14 learned, then predicted
1 0 014 1 008 0 000 1 1 008 008
0 1 000 0 000 0 000 0 0 000 00c
0 1 000 0 000 0 000 0 0 000 010
0 1 000 0 000 0 000 0 0 000 014
0 1 000 0 000 0 000 0 0 000 008
// wrong target, updated in place
1 0 014 1 00c 1 008 1 2 00c 00c
0 1 000 0 000 0 000 0 0 000 010
0 1 000 0 000 0 000 0 0 000 014
0 1 000 0 000 0 000 0 0 000 00c
// predicted taken, resolved not taken
1 0 014 0 000 1 00c 1 1 018 018
1 0 104 1 010 0 000 1 1 010 010
0 1 000 0 000 0 000 0 0 000 014
0 1 000 0 000 0 000 0 0 000 018
// fill the table and wrap the pointer
1 0 108 1 200 0 000 1 1 200 200
1 0 110 1 210 0 000 1 1 210 210
1 0 114 1 220 0 000 1 1 220 220
1 0 118 1 230 0 000 1 1 230 230
1 0 11c 1 240 0 000 1 1 240 240
1 0 120 1 250 0 000 1 1 250 250
1 0 124 1 260 0 000 1 1 260 260
1 0 128 1 100 0 000 1 1 100 100
0 1 000 0 000 0 000 0 0 000 104
0 1 000 0 000 0 000 0 0 000 108
// correct resolve, then redirect over a taken prediction
1 0 108 1 200 1 200 0 0 200 108
1 1 300 1 400 0 000 1 1 400 400
f 0 000 0 000 0 000 0 0 000 000

// ==== hw/blt_pkg.sv ====
`default_nettype none

package blt_pkg;

  // result of resolving one branch against its prediction.
  typedef enum logic [1:0] {
    OUTCOME_CORRECT,
    OUTCOME_WRONG_DIRECTION,
    OUTCOME_WRONG_TARGET
  } outcome_e;

  // sequential fetch step in bytes.
  localparam int unsigned INSTR_BYTES = 4;

  // index width for a table of the given depth, never below one bit.
  function automatic int unsigned idx_bits(input int unsigned entries);
    if (entries > 1) begin
      return $clog2(entries);
    end
    return 1;
  endfunction

endpackage

`default_nettype wire

// ==== hw/branch_lookup_table.sv ====
`default_nettype none

module branch_lookup_table #(
  parameter int ADDR_WIDTH = 32,
  parameter int BLT_SIZE   = 32
) (
  input  wire logic                  clk,
  input  wire logic                  reset,

  input  wire logic                  write,
  input  wire logic [ADDR_WIDTH-1:0] write_key,
  input  wire logic [ADDR_WIDTH-1:0] write_val,
  input  wire logic                  taken,

  input  wire logic [ADDR_WIDTH-1:0] read_key,
  output      logic [ADDR_WIDTH-1:0] read_val,
  output      logic                  read_valid
);

  import blt_pkg::*;

  localparam int IDX_W = idx_bits(BLT_SIZE);

  // key = branch pc, val = target address.
  logic [ADDR_WIDTH-1:0] keys [BLT_SIZE];
  logic [ADDR_WIDTH-1:0] vals [BLT_SIZE];
  logic [BLT_SIZE-1:0]   valid;
  logic [BLT_SIZE-1:0]   taken_bits;

  logic [IDX_W-1:0]      ptr;       // round-robin victim.
  logic [IDX_W-1:0]      ptr_next;

  logic [BLT_SIZE-1:0]   read_match;
  logic [BLT_SIZE-1:0]   write_match;
  logic [IDX_W-1:0]      read_index;
  logic [IDX_W-1:0]      write_index;
  logic                  read_hit;
  logic                  write_hit;

  assign ptr_next = (ptr == IDX_W'(BLT_SIZE - 1)) ? '0 : ptr + 1'b1;

  // parallel compare for both ports.
  always_comb begin
    for (int j = 0; j < BLT_SIZE; j++) begin
      read_match[j]  = valid[j] && (keys[j] == read_key);
      write_match[j] = valid[j] && (keys[j] == write_key);
    end
  end

  assign read_hit  = |read_match;
  assign write_hit = |write_match;

  match_encoder #(
    .WIDTH (BLT_SIZE)
  ) u_read_encoder (
    .in  (read_match),
    .out (read_index)
  );

  match_encoder #(
    .WIDTH (BLT_SIZE)
  ) u_write_encoder (
    .in  (write_match),
    .out (write_index)
  );

  // only a taken entry makes a prediction.
  assign read_valid = read_hit && taken_bits[read_index];
  assign read_val   = read_hit ? vals[read_index] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      ptr   <= '0;
    end else if (write && !write_hit) begin
      valid[ptr] <= 1'b1;
      ptr        <= ptr_next;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      if (write_hit) begin
        // existing key, update in place.
        vals[write_index]       <= write_val;
        taken_bits[write_index] <= taken;
      end else begin
        keys[ptr]       <= write_key;
        vals[ptr]       <= write_val;
        taken_bits[ptr] <= taken;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/branch_predict_top.sv ====
`default_nettype none

module branch_predict_top #(
  parameter int                    ADDR_WIDTH = 32,
  parameter int                    BLT_SIZE   = 32,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  wire logic                  clk,
  input  wire logic                  reset,

  input  wire logic                  fetch_enable,
  output      logic [ADDR_WIDTH-1:0] fetch_pc,
  output      logic                  predict_taken,
  output      logic [ADDR_WIDTH-1:0] predict_target,

  input  wire logic                  resolve_valid,
  input  wire logic [ADDR_WIDTH-1:0] resolve_pc,
  input  wire logic                  resolve_taken,
  input  wire logic [ADDR_WIDTH-1:0] resolve_target,
  input  wire logic                  predicted_taken,
  input  wire logic [ADDR_WIDTH-1:0] predicted_target,

  output      logic                  redirect,
  output      blt_pkg::outcome_e     redirect_cause,
  output      logic [ADDR_WIDTH-1:0] redirect_pc
);

  // table update from resolve.
  logic                  blt_write;
  logic [ADDR_WIDTH-1:0] blt_write_key;
  logic [ADDR_WIDTH-1:0] blt_write_val;
  logic                  blt_taken;

  fetch_pc #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RESET_PC   (RESET_PC)
  ) u_fetch_pc (
    .clk            (clk),
    .reset          (reset),
    .fetch_enable   (fetch_enable),
    .predict_taken  (predict_taken),
    .predict_target (predict_target),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .pc             (fetch_pc)
  );

  branch_lookup_table #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BLT_SIZE   (BLT_SIZE)
  ) u_blt (
    .clk        (clk),
    .reset      (reset),
    .write      (blt_write),
    .write_key  (blt_write_key),
    .write_val  (blt_write_val),
    .taken      (blt_taken),
    .read_key   (fetch_pc),
    .read_val   (predict_target),
    .read_valid (predict_taken)
  );

  resolve_branch #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_resolve (
    .resolve_valid    (resolve_valid),
    .resolve_pc       (resolve_pc),
    .resolve_taken    (resolve_taken),
    .resolve_target   (resolve_target),
    .predicted_taken  (predicted_taken),
    .predicted_target (predicted_target),
    .redirect         (redirect),
    .redirect_pc      (redirect_pc),
    .redirect_cause   (redirect_cause),
    .write            (blt_write),
    .write_key        (blt_write_key),
    .write_val        (blt_write_val),
    .taken            (blt_taken)
  );

endmodule

`default_nettype wire

// ==== hw/fetch_pc.sv ====
`default_nettype none

module fetch_pc #(
  parameter int                    ADDR_WIDTH = 32,
  parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
) (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  fetch_enable,

  input  wire logic                  predict_taken,
  input  wire logic [ADDR_WIDTH-1:0] predict_target,

  input  wire logic                  redirect,
  input  wire logic [ADDR_WIDTH-1:0] redirect_pc,

  output      logic [ADDR_WIDTH-1:0] pc
);

  import blt_pkg::*;

  logic [ADDR_WIDTH-1:0] seq_pc;
  logic [ADDR_WIDTH-1:0] next_pc;

  assign seq_pc = pc + ADDR_WIDTH'(INSTR_BYTES);

  // redirect beats prediction, prediction beats sequential.
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (fetch_enable) begin
      next_pc = predict_taken ? predict_target : seq_pc;
    end else begin
      next_pc = pc;  // stalled.
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// ==== hw/match_encoder.sv ====
`default_nettype none

module match_encoder #(
  parameter int WIDTH = 32
) (
  input  wire logic [WIDTH-1:0]                      in,
  output      logic [blt_pkg::idx_bits(WIDTH)-1:0]   out
);

  import blt_pkg::*;

  localparam int OUT_W = idx_bits(WIDTH);

  // scan from the top so the lowest set bit wins.
  always_comb begin
    out = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (in[i]) begin
        out = OUT_W'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/resolve_branch.sv ====
`default_nettype none

module resolve_branch #(
  parameter int ADDR_WIDTH = 32
) (
  input  wire logic                  resolve_valid,
  input  wire logic [ADDR_WIDTH-1:0] resolve_pc,
  input  wire logic                  resolve_taken,
  input  wire logic [ADDR_WIDTH-1:0] resolve_target,
  input  wire logic                  predicted_taken,
  input  wire logic [ADDR_WIDTH-1:0] predicted_target,

  output      logic                  redirect,
  output      logic [ADDR_WIDTH-1:0] redirect_pc,
  output      blt_pkg::outcome_e     redirect_cause,

  output      logic                  write,
  output      logic [ADDR_WIDTH-1:0] write_key,
  output      logic [ADDR_WIDTH-1:0] write_val,
  output      logic                  taken
);

  import blt_pkg::*;

  logic wrong_direction;
  logic wrong_target;

  assign wrong_direction = predicted_taken != resolve_taken;
  assign wrong_target    = predicted_taken && resolve_taken &&
                           (predicted_target != resolve_target);

  always_comb begin
    redirect_cause = OUTCOME_CORRECT;  // also when idle.
    if (resolve_valid) begin
      if (wrong_direction) begin
        redirect_cause = OUTCOME_WRONG_DIRECTION;
      end else if (wrong_target) begin
        redirect_cause = OUTCOME_WRONG_TARGET;
      end
    end
  end

  assign redirect = resolve_valid && (wrong_direction || wrong_target);

  // recovery path follows the actual direction.
  assign redirect_pc = resolve_taken ? resolve_target
                                     : resolve_pc + ADDR_WIDTH'(INSTR_BYTES);

  // taken branches allocate or refresh; a predicted-taken miss clears the taken bit.
  assign write     = resolve_valid && (resolve_taken || predicted_taken);
  assign write_key = resolve_pc;
  assign write_val = resolve_taken ? resolve_target : predicted_target;
  assign taken     = resolve_taken;

endmodule

`default_nettype wire

// ==== list.f ====
hw/blt_pkg.sv
hw/match_encoder.sv
hw/branch_lookup_table.sv
hw/resolve_branch.sv
hw/fetch_pc.sv
hw/branch_predict_top.sv
dv/branch_predict_chk.sv
dv/branch_predict_tb.sv
